// File: dma_config.svh
// DMA transport configuration
// Bus, address and length widths, lane depth and write limit

`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Memory bus data width in bits
`define DMA_DATA_WIDTH 32

// Byte address width
`define DMA_ADDR_WIDTH 16

// Transfer length width, in bytes
`define DMA_LEN_WIDTH 8

// Entries per byte-lane FIFO
`define DMA_BUFFER_DEPTH 3

// Writes granted but not yet answered
`define DMA_WR_OUTSTANDING 4

`endif

// File: bus_pkg.sv
// Memory bus package
// Word, byte-lane, address and length types of the OBI-style bus

`default_nettype none

`include "dma_config.svh"

package bus_pkg;

    // Lanes per bus word
    localparam int unsigned NUM_LANES = `DMA_DATA_WIDTH / 8;

    typedef logic [7:0] byte_t;

    // One bit per byte lane
    typedef logic [NUM_LANES-1:0] strb_t;

    // Byte offset inside a word
    typedef logic [$clog2(NUM_LANES)-1:0] offs_t;

    typedef logic [`DMA_DATA_WIDTH-1:0] data_t;
    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DMA_LEN_WIDTH-1:0]  len_t;

endpackage

`default_nettype wire

// File: dp_pkg.sv
// Data path package
// Transfer job types, source protocol and word masking helpers

`default_nettype none

package dp_pkg;

    import bus_pkg::*;

    typedef enum logic {
        PROTO_OBI  = 1'b0,
        PROTO_INIT = 1'b1
    } protocol_e;

    typedef struct packed {
        addr_t     src_addr;
        len_t      length;
        protocol_e protocol;
        byte_t     init_byte;
    } rd_job_t;

    typedef struct packed {
        addr_t dst_addr;
        len_t  length;
    } wr_job_t;

    // Bytes of the job that fall into the current word
    function automatic len_t word_bytes(offs_t first_off, len_t remaining);
        len_t avail;
        avail = len_t'(NUM_LANES) - len_t'(first_off);
        return (remaining < avail) ? remaining : avail;
    endfunction

    // Bus lanes that hold job bytes, in memory lane order
    function automatic strb_t word_mask(offs_t first_off, len_t nbytes);
        strb_t mask;
        for (int j = 0; j < NUM_LANES; j++) begin
            mask[j] = (j >= int'(first_off)) && (j < int'(first_off) + int'(nbytes));
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: byte_lane_fifo.sv
// Byte lane FIFO
// Circular buffer of DEPTH bytes with valid/ready on both sides

`timescale 1ns/10ps
`default_nettype none

`include "dma_config.svh"

module byte_lane_fifo
    import bus_pkg::*;
#(
    parameter int unsigned DEPTH = `DMA_BUFFER_DEPTH
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  byte_t data_i,
    input  logic  push_i,
    output logic  ready_o,
    output byte_t data_o,
    output logic  valid_o,
    input  logic  pop_i
);

    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    byte_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign ready_o = (count_q != CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign data_o  = mem[rd_ptr_q];
    assign do_push = push_i && ready_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) mem[wr_ptr_q] <= data_i;
    end

    // The read port checks ready before it pushes
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> ready_o
    );

    // The write port pops only lanes it saw valid
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> valid_o
    );

endmodule

`default_nettype wire

// File: dma_read_port.sv
// DMA read port
// Fetches source words over OBI or makes fill words, rotates them
// into stream lane order and pushes the job bytes into the lanes

`timescale 1ns/10ps
`default_nettype none

module dma_read_port
    import bus_pkg::*, dp_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rd_job_t               job_i,
    input  logic                  job_valid_i,
    output logic                  job_ready_o,
    output logic                  done_o,
    output logic                  rd_req_o,
    output addr_t                 rd_addr_o,
    input  logic                  rd_gnt_i,
    input  logic                  rd_rvalid_i,
    input  data_t                 rd_rdata_i,
    output byte_t [NUM_LANES-1:0] lane_data_o,
    output strb_t                 lane_push_o,
    input  strb_t                 lane_ready_i
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_WAIT,
        RD_PUSH
    } rd_state_e;

    rd_state_e state_q, state_d;
    addr_t     addr_q;
    len_t      remaining_q;
    offs_t     shift_q;
    logic      first_q;
    protocol_e proto_q;
    logic      done_q;

    // Fill byte and returned word
    byte_t     init_q;
    data_t     hold_q;

    data_t                      word;
    logic [2*$bits(data_t)-1:0] word_tmp;
    offs_t                      first_off;
    len_t                       nbytes;
    strb_t                      src_mask;
    strb_t                      push_mask;
    logic                       push_fire;
    logic                       last_word;

    // ------------------------------
    // Word select and barrel shift
    // ------------------------------

    always_comb begin
        word      = (proto_q == PROTO_INIT) ? {NUM_LANES{init_q}} : hold_q;
        // Rotate down so source byte k lands in lane k mod 4
        word_tmp  = {word, word} >> (shift_q * 8);
        first_off = first_q ? shift_q : '0;
        nbytes    = word_bytes(first_off, remaining_q);
        src_mask  = word_mask(first_off, nbytes);
        push_mask = strb_t'({src_mask, src_mask} >> shift_q);
        // All lanes of this word must take their byte together
        push_fire = (state_q == RD_PUSH) && ((push_mask & ~lane_ready_i) == '0);
        last_word = (remaining_q == nbytes);
    end

    assign lane_data_o = word_tmp[$bits(data_t)-1:0];
    assign lane_push_o = push_fire ? push_mask : '0;
    assign rd_req_o    = (state_q == RD_REQ);
    assign rd_addr_o   = addr_q;
    assign job_ready_o = (state_q == RD_IDLE);
    assign done_o      = done_q;

    // ------------------------------
    // Control FSM
    // ------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (job_valid_i) begin
                    state_d = (job_i.protocol == PROTO_INIT) ? RD_PUSH : RD_REQ;
                end
            end
            RD_REQ: begin
                if (rd_gnt_i) state_d = RD_WAIT;
            end
            RD_WAIT: begin
                if (rd_rvalid_i) state_d = RD_PUSH;
            end
            RD_PUSH: begin
                if (push_fire) begin
                    if (last_word) begin
                        state_d = RD_IDLE;
                    end else if (proto_q == PROTO_OBI) begin
                        state_d = RD_REQ;
                    end
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= RD_IDLE;
            addr_q      <= '0;
            remaining_q <= '0;
            shift_q     <= '0;
            first_q     <= 1'b0;
            proto_q     <= PROTO_OBI;
            done_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= push_fire && last_word;
            if (job_valid_i && job_ready_o) begin
                // Word aligned start, offset kept for the rotation
                addr_q      <= job_i.src_addr & ~addr_t'(NUM_LANES - 1);
                remaining_q <= job_i.length;
                shift_q     <= offs_t'(job_i.src_addr);
                first_q     <= 1'b1;
                proto_q     <= job_i.protocol;
            end else if (push_fire) begin
                addr_q      <= addr_q + addr_t'(NUM_LANES);
                remaining_q <= remaining_q - nbytes;
                first_q     <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (job_valid_i && job_ready_o) init_q <= job_i.init_byte;
        if ((state_q == RD_WAIT) && rd_rvalid_i) hold_q <= rd_rdata_i;
    end

    // A word stalled by full lanes keeps its bytes and lanes until pushed
    a_push_hold: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ((state_q == RD_PUSH) && !push_fire) |=>
            ((state_q == RD_PUSH) && $stable(lane_data_o) && $stable(push_mask))
    );

endmodule

`default_nettype wire

// File: dma_write_port.sv
// DMA write port
// Pops the byte lanes, rotates them to the destination alignment,
// issues OBI writes with byte enables and waits for the responses

`timescale 1ns/10ps
`default_nettype none

`include "dma_config.svh"

module dma_write_port
    import bus_pkg::*, dp_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  wr_job_t               job_i,
    input  logic                  job_valid_i,
    output logic                  job_ready_o,
    output logic                  done_o,
    input  byte_t [NUM_LANES-1:0] lane_q_i,
    input  strb_t                 lane_valid_i,
    output strb_t                 lane_pop_o,
    output logic                  wr_req_o,
    output addr_t                 wr_addr_o,
    output strb_t                 wr_be_o,
    output data_t                 wr_wdata_o,
    input  logic                  wr_gnt_i,
    input  logic                  wr_rvalid_i
);

    localparam int unsigned MAX_OUT = `DMA_WR_OUTSTANDING;
    localparam int unsigned OUT_W   = $clog2(MAX_OUT + 1);

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_DRAIN
    } wr_state_e;

    wr_state_e        state_q, state_d;
    addr_t            addr_q;
    len_t             remaining_q;
    offs_t            shift_q;
    logic             first_q;
    logic             done_q;
    logic [OUT_W-1:0] outstanding_q, outstanding_d;

    offs_t                      first_off;
    len_t                       nbytes;
    strb_t                      be;
    strb_t                      pop_need;
    logic [2*$bits(data_t)-1:0] data_tmp;
    data_t                      wdata;
    logic                       issue;
    logic                       grant;
    logic                       last_word;

    // ------------------------------
    // Byte enables and barrel shift
    // ------------------------------

    always_comb begin
        first_off = first_q ? shift_q : '0;
        nbytes    = word_bytes(first_off, remaining_q);
        be        = word_mask(first_off, nbytes);
        // Destination lane j takes stream lane (j - offset) mod 4
        pop_need  = strb_t'({be, be} >> shift_q);
        data_tmp  = {lane_q_i, lane_q_i} << (shift_q * 8);
        wdata     = data_tmp[2*$bits(data_t)-1 -: $bits(data_t)];
        // Bytes outside the job go out as zero
        for (int j = 0; j < NUM_LANES; j++) begin
            if (!be[j]) wdata[8*j +: 8] = '0;
        end
        issue     = (state_q == WR_DATA)
                    && ((pop_need & ~lane_valid_i) == '0)
                    && (outstanding_q < OUT_W'(MAX_OUT));
        grant     = issue && wr_gnt_i;
        last_word = (remaining_q == nbytes);
        outstanding_d = outstanding_q + OUT_W'(grant) - OUT_W'(wr_rvalid_i);
    end

    // Lane heads stay put until the grant, which holds the request stable
    assign wr_req_o    = issue;
    assign wr_addr_o   = addr_q;
    assign wr_be_o     = be;
    assign wr_wdata_o  = wdata;
    assign lane_pop_o  = grant ? pop_need : '0;
    assign job_ready_o = (state_q == WR_IDLE);
    assign done_o      = done_q;

    // ------------------------------
    // Control FSM
    // ------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: begin
                if (job_valid_i) state_d = WR_DATA;
            end
            WR_DATA: begin
                if (grant && last_word) state_d = WR_DRAIN;
            end
            WR_DRAIN: begin
                if (outstanding_d == '0) state_d = WR_IDLE;
            end
            default: state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= WR_IDLE;
            addr_q        <= '0;
            remaining_q   <= '0;
            shift_q       <= '0;
            first_q       <= 1'b0;
            done_q        <= 1'b0;
            outstanding_q <= '0;
        end else begin
            state_q       <= state_d;
            outstanding_q <= outstanding_d;
            // Job ends with its last response
            done_q        <= (state_q == WR_DRAIN) && (outstanding_d == '0);
            if (job_valid_i && job_ready_o) begin
                addr_q      <= job_i.dst_addr & ~addr_t'(NUM_LANES - 1);
                remaining_q <= job_i.length;
                shift_q     <= offs_t'(job_i.dst_addr);
                first_q     <= 1'b1;
            end else if (grant) begin
                addr_q      <= addr_q + addr_t'(NUM_LANES);
                remaining_q <= remaining_q - nbytes;
                first_q     <= 1'b0;
            end
        end
    end

    // Memory side must never see more writes in flight than the limit
    a_outstanding_max: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        outstanding_q <= OUT_W'(MAX_OUT)
    );

endmodule

`default_nettype wire

// File: dma_transport.sv
// DMA transport layer
// Read port, four byte-lane FIFOs and write port between two OBI-style buses

`timescale 1ns/10ps
`default_nettype none

module dma_transport
    import bus_pkg::*, dp_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Read job
    input  addr_t     r_src_addr_i,
    input  len_t      r_length_i,
    input  protocol_e r_protocol_i,
    input  byte_t     r_init_byte_i,
    input  logic      r_dp_valid_i,
    output logic      r_dp_ready_o,
    output logic      r_done_o,

    // Write job
    input  addr_t     w_dst_addr_i,
    input  len_t      w_length_i,
    input  logic      w_dp_valid_i,
    output logic      w_dp_ready_o,
    output logic      w_done_o,

    // OBI read bus
    output logic      rd_req_o,
    output addr_t     rd_addr_o,
    input  logic      rd_gnt_i,
    input  logic      rd_rvalid_i,
    input  data_t     rd_rdata_i,

    // OBI write bus
    output logic      wr_req_o,
    output addr_t     wr_addr_o,
    output strb_t     wr_be_o,
    output data_t     wr_wdata_o,
    input  logic      wr_gnt_i,
    input  logic      wr_rvalid_i,

    output logic      buffer_busy_o
);

    rd_job_t               r_job;
    wr_job_t               w_job;
    byte_t [NUM_LANES-1:0] lane_data;
    byte_t [NUM_LANES-1:0] lane_q;
    strb_t                 lane_push;
    strb_t                 lane_ready;
    strb_t                 lane_valid;
    strb_t                 lane_pop;

    assign r_job = '{
        src_addr:  r_src_addr_i,
        length:    r_length_i,
        protocol:  r_protocol_i,
        init_byte: r_init_byte_i
    };

    assign w_job = '{dst_addr: w_dst_addr_i, length: w_length_i};

    // ------------------------------
    // Read side
    // ------------------------------

    dma_read_port i_read_port (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .job_i        ( r_job        ),
        .job_valid_i  ( r_dp_valid_i ),
        .job_ready_o  ( r_dp_ready_o ),
        .done_o       ( r_done_o     ),
        .rd_req_o     ( rd_req_o     ),
        .rd_addr_o    ( rd_addr_o    ),
        .rd_gnt_i     ( rd_gnt_i     ),
        .rd_rvalid_i  ( rd_rvalid_i  ),
        .rd_rdata_i   ( rd_rdata_i   ),
        .lane_data_o  ( lane_data    ),
        .lane_push_o  ( lane_push    ),
        .lane_ready_i ( lane_ready   )
    );

    // ------------------------------
    // Byte lanes
    // ------------------------------

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        byte_lane_fifo i_lane (
            .clk_i   ( clk_i         ),
            .rst_n_i ( rst_n_i       ),
            .data_i  ( lane_data[i]  ),
            .push_i  ( lane_push[i]  ),
            .ready_o ( lane_ready[i] ),
            .data_o  ( lane_q[i]     ),
            .valid_o ( lane_valid[i] ),
            .pop_i   ( lane_pop[i]   )
        );
    end

    // ------------------------------
    // Write side
    // ------------------------------

    dma_write_port i_write_port (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .job_i        ( w_job        ),
        .job_valid_i  ( w_dp_valid_i ),
        .job_ready_o  ( w_dp_ready_o ),
        .done_o       ( w_done_o     ),
        .lane_q_i     ( lane_q       ),
        .lane_valid_i ( lane_valid   ),
        .lane_pop_o   ( lane_pop     ),
        .wr_req_o     ( wr_req_o     ),
        .wr_addr_o    ( wr_addr_o    ),
        .wr_be_o      ( wr_be_o      ),
        .wr_wdata_o   ( wr_wdata_o   ),
        .wr_gnt_i     ( wr_gnt_i     ),
        .wr_rvalid_i  ( wr_rvalid_i  )
    );

    // Any lane holding a byte keeps the buffer busy
    assign buffer_busy_o = |lane_valid;

endmodule

`default_nettype wire

// File: tb_dma_transport.sv
// DMA transport testbench
// Runs copy and fill jobs from a pattern file against a byte memory model
// with random grant and response stalls, then compares the memory contents

`timescale 1ns/10ps
`default_nettype none

module tb_dma_transport
    import bus_pkg::*, dp_pkg::*;
;

    logic      clk_i = 1'b0;
    logic      rst_n_i = 1'b0;
    addr_t     r_src_addr_i = '0;
    len_t      r_length_i = '0;
    protocol_e r_protocol_i = PROTO_OBI;
    byte_t     r_init_byte_i = '0;
    logic      r_dp_valid_i = 1'b0;
    logic      r_dp_ready_o;
    logic      r_done_o;
    addr_t     w_dst_addr_i = '0;
    len_t      w_length_i = '0;
    logic      w_dp_valid_i = 1'b0;
    logic      w_dp_ready_o;
    logic      w_done_o;
    logic      rd_req_o;
    addr_t     rd_addr_o;
    logic      rd_gnt_i = 1'b0;
    logic      rd_rvalid_i = 1'b0;
    data_t     rd_rdata_i = '0;
    logic      wr_req_o;
    addr_t     wr_addr_o;
    strb_t     wr_be_o;
    data_t     wr_wdata_o;
    logic      wr_gnt_i = 1'b0;
    logic      wr_rvalid_i = 1'b0;
    logic      buffer_busy_o;

    byte_t       mem [65536];
    byte_t       shadow [65536];
    rd_job_t     rd_jobs [$];
    wr_job_t     wr_jobs [$];
    logic [15:0] lfsr_q = 16'd50;
    addr_t       rd_addr_l = '0;
    int unsigned rd_wait = 0;
    int unsigned bus_cyc = 0;
    int unsigned wr_due_q [$];
    len_t        r_done_cnt = '0;
    len_t        w_done_cnt = '0;
    logic        busy_seen = 1'b0;
    int unsigned cycle_cnt = 0;
    int unsigned timeout_limit = 50;
    int          errors = 0;

    dma_transport DUT (.*);

    always #2 clk_i = ~clk_i;

    // ------------------------------
    // Random source and checks
    // ------------------------------

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    // One to three cycles
    function automatic int unsigned delay_cycles();
        int unsigned b;
        b = rand_bit();
        b = 2 * b + rand_bit();
        return (b == 3) ? 2 : b + 1;
    endfunction

    task automatic check_byte(input addr_t addr, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("Error mem[%h]: got %h, expected %h", addr, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input len_t got, input len_t exp);
        if (got !== exp) begin
            $display("Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------

    always @(posedge clk_i) begin : bus_model
        int unsigned due;
        if (rst_n_i) begin
            bus_cyc++;
            if (rd_req_o && rd_gnt_i) begin
                rd_addr_l = rd_addr_o;
                rd_wait   = delay_cycles();
            end
            if (wr_req_o && wr_gnt_i) begin
                for (int j = 0; j < NUM_LANES; j++) begin
                    if (wr_be_o[j]) mem[addr_t'(wr_addr_o + j)] = wr_wdata_o[8*j +: 8];
                end
                // Responses keep grant order, at most one per cycle
                due = bus_cyc + delay_cycles();
                if (wr_due_q.size() > 0 && due <= wr_due_q[$]) due = wr_due_q[$] + 1;
                wr_due_q.push_back(due);
            end
            #0.5;
            rd_gnt_i    = rand_bit() | rand_bit();
            wr_gnt_i    = rand_bit() | rand_bit();
            rd_rvalid_i = 1'b0;
            if (rd_wait != 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    rd_rvalid_i = 1'b1;
                    rd_rdata_i  = {mem[addr_t'(rd_addr_l + 3)], mem[addr_t'(rd_addr_l + 2)],
                                   mem[addr_t'(rd_addr_l + 1)], mem[rd_addr_l]};
                end
            end
            wr_rvalid_i = 1'b0;
            if (wr_due_q.size() > 0 && wr_due_q[0] == bus_cyc) begin
                wr_rvalid_i = 1'b1;
                void'(wr_due_q.pop_front());
            end
        end
    end

    always @(posedge clk_i) begin
        if (r_done_o) r_done_cnt <= r_done_cnt + 1'b1;
        if (w_done_o) w_done_cnt <= w_done_cnt + 1'b1;
        if (buffer_busy_o) busy_seen <= 1'b1;
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout after %0d cycles, a done pulse or bus handshake never came",
                     cycle_cnt);
            $display("Run ended with %0d errors", errors + 1);
            $display("** FAIL **");
            $finish;
        end
    end

    // ------------------------------
    // Job sequencing
    // ------------------------------

    task automatic load_patterns();
        int    fd;
        int    n;
        int    proto;
        int    src;
        int    dst;
        int    len;
        int    fill;
        string line;
        fd = $fopen("dma_patterns.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the pattern file dma_patterns.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) && line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %d %h", proto, src, dst, len, fill);
                    if (n == 5) begin
                        rd_jobs.push_back(rd_job_t'{addr_t'(src), len_t'(len),
                                                    protocol_e'(proto), byte_t'(fill)});
                        wr_jobs.push_back(wr_job_t'{addr_t'(dst), len_t'(len)});
                        timeout_limit += (len / 4 + 2) * 8;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_job(input int k);
        rd_job_t rj;
        wr_job_t wj;
        logic    r_taken;
        logic    w_taken;
        byte_t   exp;
        rj      = rd_jobs[k];
        wj      = wr_jobs[k];
        r_taken = 1'b0;
        w_taken = 1'b0;
        for (int i = 0; i < int'(rj.length); i++) begin
            exp = (rj.protocol == PROTO_INIT) ? rj.init_byte : shadow[addr_t'(rj.src_addr + i)];
            shadow[addr_t'(wj.dst_addr + i)] = exp;
        end
        @(posedge clk_i);
        #0.5;
        r_src_addr_i  = rj.src_addr;
        r_length_i    = rj.length;
        r_protocol_i  = rj.protocol;
        r_init_byte_i = rj.init_byte;
        r_dp_valid_i  = 1'b1;
        w_dst_addr_i  = wj.dst_addr;
        w_length_i    = wj.length;
        w_dp_valid_i  = 1'b1;
        while (!(r_taken && w_taken)) begin
            @(posedge clk_i);
            if (r_dp_valid_i && r_dp_ready_o) r_taken = 1'b1;
            if (w_dp_valid_i && w_dp_ready_o) w_taken = 1'b1;
            #0.5;
            if (r_taken) r_dp_valid_i = 1'b0;
            if (w_taken) w_dp_valid_i = 1'b0;
        end
        while (r_done_cnt < len_t'(k + 1) || w_done_cnt < len_t'(k + 1)) begin
            @(posedge clk_i);
            #0.5;
        end
        // A few more cycles to catch a second done pulse
        repeat (3) @(posedge clk_i);
        #0.5;
        check_count("r_done_o count", r_done_cnt, len_t'(k + 1));
        check_count("w_done_o count", w_done_cnt, len_t'(k + 1));
        for (int a = int'(wj.dst_addr) - 4; a < int'(wj.dst_addr) + int'(rj.length) + 4; a++) begin
            check_byte(addr_t'(a), mem[addr_t'(a)], shadow[addr_t'(a)]);
        end
    endtask

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a]    = byte_t'(a) ^ byte_t'(a >> 8) ^ 8'h5A;
            shadow[a] = mem[a];
        end
        load_patterns();
        repeat (5) @(posedge clk_i);
        #0.5;
        rst_n_i = 1'b1;
        check_flag("r_dp_ready_o", r_dp_ready_o, 1'b1);
        check_flag("w_dp_ready_o", w_dp_ready_o, 1'b1);
        check_flag("rd_req_o", rd_req_o, 1'b0);
        check_flag("wr_req_o", wr_req_o, 1'b0);
        check_flag("r_done_o", r_done_o, 1'b0);
        check_flag("w_done_o", w_done_o, 1'b0);
        check_flag("buffer_busy_o", buffer_busy_o, 1'b0);
        for (int k = 0; k < rd_jobs.size(); k++) begin
            run_job(k);
        end
        repeat (4) @(posedge clk_i);
        #0.5;
        check_flag("buffer_busy_o during jobs", busy_seen, 1'b1);
        check_flag("buffer_busy_o", buffer_busy_o, 1'b0);
        check_flag("r_dp_ready_o", r_dp_ready_o, 1'b1);
        check_flag("w_dp_ready_o", w_dp_ready_o, 1'b1);
        $display("Ran %0d jobs with %0d errors", rd_jobs.size(), errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dma_patterns.txt
# proto (0 = OBI copy, 1 = INIT fill), src_addr hex, dst_addr hex, length decimal, fill hex
# Each job moves length bytes from src_addr to dst_addr
0 0100 2000 16 00
0 0201 2104 13 00
0 0302 2207 21 00
0 0403 2301 30 00
0 0500 2402 9 00
0 0611 2513 1 00
0 0702 2600 3 00
1 0000 2703 11 a5
1 0000 2800 16 3c
1 0002 2902 2 0f
0 0a03 2a03 25 00
0 2000 3001 16 00

// File: compile.f
+incdir+.
bus_pkg.sv
dp_pkg.sv
byte_lane_fifo.sv
dma_read_port.sv
dma_write_port.sv
dma_transport.sv
tb_dma_transport.sv

// File: Bender.yml
package:
  name: dma_transport

sources:
  - include_dirs:
      - .
    files:
      - bus_pkg.sv
      - dp_pkg.sv
      - byte_lane_fifo.sv
      - dma_read_port.sv
      - dma_write_port.sv
      - dma_transport.sv
  - target: test
    files:
      - tb_dma_transport.sv
